// ==== build.f ====
hw/div_cfg_pkg.sv
hw/div_op_pkg.sv
hw/div_operand_if.sv
hw/div_array_cell.sv
hw/div_array.sv
hw/div_operand_stage.sv
hw/div_except_classify.sv
hw/div_result_merge.sv
hw/div_unit_top.sv
bench/tb_clock_gen.sv
bench/div_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the divide unit testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module div_unit_tb -f build.f -o div_unit_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/div_unit_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Done: no errors"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// ==== bench/div_unit_tb.sv ====
module div_unit_tb;

  localparam int width = div_cfg_pkg::default_width;
  localparam logic [width-1:0] most_neg = {1'b1, {(width-1){1'b0}}};
  localparam int drain_limit = 64;

  typedef struct packed {
    logic             sgn;
    logic [width-1:0] a;
    logic [width-1:0] b;
    logic [width-1:0] quot;
    logic [width-1:0] rem;
    logic             dbz;
    logic             ovf;
    int               issue_cycle;
  } expect_t;

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  logic             mode_signed;
  logic [width-1:0] dividend;
  logic [width-1:0] divisor;
  logic             out_valid;
  logic [width-1:0] quotient;
  logic [width-1:0] remainder;
  logic             div_by_zero;
  logic             overflow;

  integer  seed;
  int      errors;
  int      checks;
  int      cycle;
  int      test_start;
  expect_t exp_q[$];

  tb_clock_gen u_clock_gen (.clk(clk));

  div_unit_top #(.width(width)) i_div_unit_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .mode_signed (mode_signed),
    .dividend    (dividend),
    .divisor     (divisor),
    .out_valid   (out_valid),
    .quotient    (quotient),
    .remainder   (remainder),
    .div_by_zero (div_by_zero),
    .overflow    (overflow)
  );

  function automatic logic [width-1:0] rand_word();
    int r;
    r = $random(seed);
    return r[width-1:0];
  endfunction

  // reference division, truncating toward zero in signed mode.
  function automatic expect_t model_result(input logic sgn, input logic [width-1:0] a,
                                           input logic [width-1:0] b, input int issue);
    expect_t                 e;
    logic signed [width-1:0] sa;
    logic signed [width-1:0] sb;
    sa            = a;
    sb            = b;
    e.sgn         = sgn;
    e.a           = a;
    e.b           = b;
    e.dbz         = 1'b0;
    e.ovf         = 1'b0;
    e.issue_cycle = issue;
    if (b == '0) begin
      e.quot = '1;
      e.rem  = a;
      e.dbz  = 1'b1;
    end else if (sgn && a == most_neg && b == '1) begin
      e.quot = a;
      e.rem  = '0;
      e.ovf  = 1'b1;
    end else if (sgn) begin
      e.quot = sa / sb;
      e.rem  = sa % sb;
    end else begin
      e.quot = a / b;
      e.rem  = a % b;
    end
    return e;
  endfunction

  task automatic check_result(input expect_t e);
    checks++;
    assert (quotient == e.quot && remainder == e.rem) else begin
      $display("error at %0t: %0s %h / %h gave q %h r %h, expected q %h r %h", $time,
               e.sgn ? "signed" : "unsigned", e.a, e.b, quotient, remainder, e.quot, e.rem);
      errors++;
    end
    assert (div_by_zero == e.dbz && overflow == e.ovf) else begin
      $display("error at %0t: flags dbz %b ovf %b for %h / %h, expected %b %b", $time,
               div_by_zero, overflow, e.a, e.b, e.dbz, e.ovf);
      errors++;
    end
    assert (cycle - e.issue_cycle == div_cfg_pkg::pipe_latency) else begin
      $display("error at %0t: result came %0d cycles after request", $time,
               cycle - e.issue_cycle);
      errors++;
    end
  endtask

  // samples the values the DUT sees at each edge.
  always @(posedge clk) begin : b_monitor
    expect_t e;
    cycle = cycle + 1;
    if (!rst_n) begin
      checks++;
      assert (out_valid == 1'b0) else begin
        $display("error at %0t: out_valid high during reset", $time);
        errors++;
      end
    end else begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          $display("error at %0t: out_valid with no request pending", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          check_result(e);
        end
      end
      if (in_valid) begin
        exp_q.push_back(model_result(mode_signed, dividend, divisor, cycle));
      end
    end
  end

  task automatic issue_op(input logic sgn, input logic [width-1:0] a, input logic [width-1:0] b);
    @(posedge clk);
    in_valid    <= 1'b1;
    mode_signed <= sgn;
    dividend    <= a;
    divisor     <= b;
  endtask

  task automatic go_idle();
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d results never came out of the DUT", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic report_test(input string name);
    $display("test %-16s %s (%0d errors)", name, (errors == test_start) ? "ok" : "failed",
             errors - test_start);
    test_start = errors;
  endtask

  initial begin
    seed        = 32'hededd10c;
    errors      = 0;
    checks      = 0;
    cycle       = 0;
    test_start  = 0;
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    mode_signed = 1'b0;
    dividend    = '0;
    divisor     = '0;

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    report_test("reset");

    repeat (200) issue_op(1'b0, rand_word(), rand_word()); // one per cycle.
    go_idle();
    wait_drain();
    report_test("unsigned random");

    repeat (200) issue_op(1'b1, rand_word(), rand_word());
    go_idle();
    wait_drain();
    report_test("signed random");

    issue_op(1'b0, '0, '0);
    issue_op(1'b1, most_neg, '0);
    issue_op(1'b0, most_neg, '0);
    repeat (16) issue_op(1'(rand_word() % 2), rand_word(), '0);
    go_idle();
    wait_drain();
    report_test("divide by zero");

    issue_op(1'b1, most_neg, '1);
    issue_op(1'b0, most_neg, '1); // plain unsigned result here.
    issue_op(1'b1, most_neg, width'(1));
    issue_op(1'b1, most_neg + 1'b1, '1);
    go_idle();
    wait_drain();
    report_test("signed overflow");

    // sparse requests with random gaps, then a quiet stretch.
    repeat (40) begin
      issue_op(1'(rand_word() % 2), rand_word(), rand_word());
      repeat (rand_word() % 4) go_idle();
    end
    go_idle();
    repeat (20) go_idle();
    wait_drain();
    report_test("latency and idle");

    $display("tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int half_period = 4
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk; // period of 8.
  end

endmodule

// ==== hw/div_unit_top.sv ====
module div_unit_top #(
  parameter int width = div_cfg_pkg::default_width
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic             mode_signed,
  input  logic [width-1:0] dividend,
  input  logic [width-1:0] divisor,

  output logic             out_valid,
  output logic [width-1:0] quotient,
  output logic [width-1:0] remainder,
  output logic             div_by_zero,
  output logic             overflow
);

  logic [width-1:0]         mag_quot;
  logic [width-1:0]         mag_rem;
  div_op_pkg::except_kind_t except_kind;

  div_operand_if #(.width(width)) op_if (.clk(clk));

  div_operand_stage #(.width(width)) u_operand_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .mode_signed (mode_signed),
    .dividend    (dividend),
    .divisor     (divisor),
    .op          (op_if.src)
  );

  div_array #(.width(width)) u_array (
    .op       (op_if.dst),
    .mag_quot (mag_quot),
    .mag_rem  (mag_rem)
  );

  div_except_classify #(.width(width)) u_except_classify (
    .op          (op_if.dst),
    .except_kind (except_kind)
  );

  div_result_merge #(.width(width)) u_result_merge (
    .clk         (clk),
    .rst_n       (rst_n),
    .op          (op_if.dst),
    .mag_quot    (mag_quot),
    .mag_rem     (mag_rem),
    .except_kind (except_kind),
    .out_valid   (out_valid),
    .quotient    (quotient),
    .remainder   (remainder),
    .div_by_zero (div_by_zero),
    .overflow    (overflow)
  );

  // every request comes out a fixed number of cycles later.
  a_fixed_latency: assert property (
    @(posedge clk) disable iff (!rst_n)
    in_valid |-> ##(div_cfg_pkg::pipe_latency) out_valid
  );

endmodule

// ==== hw/div_result_merge.sv ====
module div_result_merge #(
  parameter int width = div_cfg_pkg::default_width
) (
  input  logic                     clk,
  input  logic                     rst_n,

  div_operand_if.dst               op,

  input  logic [width-1:0]         mag_quot,
  input  logic [width-1:0]         mag_rem,
  input  div_op_pkg::except_kind_t except_kind,

  output logic                     out_valid,
  output logic [width-1:0]         quotient,
  output logic [width-1:0]         remainder,
  output logic                     div_by_zero,
  output logic                     overflow
);

  logic [width-1:0]     sgn_quot;
  logic [width-1:0]     sgn_rem;
  div_op_pkg::res_src_t quot_src;
  div_op_pkg::res_src_t rem_src;

  function automatic logic [width-1:0] pick_value(
    input div_op_pkg::res_src_t src,
    input logic [width-1:0]     computed,
    input logic [width-1:0]     raw_dividend
  );
    case (src)
      div_op_pkg::res_all_ones: return '1;
      div_op_pkg::res_dividend: return raw_dividend;
      div_op_pkg::res_zero:     return '0;
      default:                  return computed;
    endcase
  endfunction

  assign sgn_quot = op.neg_quot ? (~mag_quot + 1'b1) : mag_quot;
  assign sgn_rem  = op.neg_rem ? (~mag_rem + 1'b1) : mag_rem;

  always_comb begin
    quot_src = div_op_pkg::res_computed;
    rem_src  = div_op_pkg::res_computed;
    case (except_kind)
      div_op_pkg::div_by_zero: begin
        quot_src = div_op_pkg::dbz_quot_src;
        rem_src  = div_op_pkg::dbz_rem_src;
      end
      div_op_pkg::signed_overflow: begin
        quot_src = div_op_pkg::ovf_quot_src;
        rem_src  = div_op_pkg::ovf_rem_src;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid   <= 1'b0;
      div_by_zero <= 1'b0;
      overflow    <= 1'b0;
    end else begin
      out_valid   <= op.valid;
      div_by_zero <= op.valid && (except_kind == div_op_pkg::div_by_zero);
      overflow    <= op.valid && (except_kind == div_op_pkg::signed_overflow);
    end
  end

  always_ff @(posedge clk) begin
    quotient  <= pick_value(quot_src, sgn_quot, op.dividend);
    remainder <= pick_value(rem_src, sgn_rem, op.dividend);
  end

  a_one_flag: assert property (
    @(posedge clk) disable iff (!rst_n) !(div_by_zero && overflow)
  );

endmodule

// ==== hw/div_except_classify.sv ====
module div_except_classify #(
  parameter int width = div_cfg_pkg::default_width
) (
  div_operand_if.dst                op,

  output div_op_pkg::except_kind_t except_kind
);

  localparam logic [width-1:0] most_neg = {1'b1, {(width-1){1'b0}}};

  logic dvs_zero;
  logic ovf_hit;

  assign dvs_zero = (op.divisor == '0);

  // minus one is all ones in two's complement.
  assign ovf_hit = op.mode_signed && (op.dividend == most_neg) && (op.divisor == '1);

  always_comb begin
    if (dvs_zero) begin
      except_kind = div_op_pkg::div_by_zero; // wins over overflow.
    end else if (ovf_hit) begin
      except_kind = div_op_pkg::signed_overflow;
    end else begin
      except_kind = div_op_pkg::none;
    end
  end

endmodule

// ==== hw/div_operand_stage.sv ====
module div_operand_stage #(
  parameter int width = div_cfg_pkg::default_width
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic             mode_signed,
  input  logic [width-1:0] dividend,
  input  logic [width-1:0] divisor,

  div_operand_if.src       op
);

  logic             dvd_neg;
  logic             dvs_neg;
  logic [width-1:0] dvd_abs;
  logic [width-1:0] dvs_abs;

  // sign bits only count in signed mode.
  assign dvd_neg = mode_signed & dividend[width-1];
  assign dvs_neg = mode_signed & divisor[width-1];

  // the most negative value maps onto itself, which is its magnitude unsigned.
  assign dvd_abs = dvd_neg ? (~dividend + 1'b1) : dividend;
  assign dvs_abs = dvs_neg ? (~divisor + 1'b1) : divisor;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op.valid <= 1'b0;
    end else begin
      op.valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    op.mode_signed  <= mode_signed;
    op.dividend     <= dividend;
    op.divisor      <= divisor;
    op.mag_dividend <= dvd_abs;
    op.mag_divisor  <= dvs_abs;
    op.neg_quot     <= dvd_neg ^ dvs_neg;
    op.neg_rem      <= dvd_neg;
  end

  a_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(op.valid)
  );

endmodule

// ==== hw/div_array.sv ====
module div_array #(
  parameter int width = div_cfg_pkg::default_width
) (
  div_operand_if.dst      op,

  output logic [width-1:0] mag_quot,
  output logic [width-1:0] mag_rem
);

  // partial remainder entering each row, the last entry is the final one.
  logic [width-1:0] part_rem  [width+1];
  // trial value of a row, previous remainder with the next dividend bit shifted in.
  logic [width:0]   shifted   [width];
  // divisor bits as they pass down the grid.
  logic [width:0]   div_row   [width+1];
  logic [width+1:0] borrow_row [width];
  logic [width:0]   rem_row   [width];
  logic [width-1:0] keep;

  assign part_rem[0] = '0;
  assign div_row[0]  = {1'b0, op.mag_divisor};

  generate
    genvar r, c;

    for (r = 0; r < width; r++) begin : g_row
      assign shifted[r]       = {part_rem[r], op.mag_dividend[width-1-r]};
      assign borrow_row[r][0] = 1'b0;

      // final borrow set means the divisor did not fit.
      assign keep[r]              = borrow_row[r][width+1];
      assign mag_quot[width-1-r]  = ~keep[r];

      for (c = 0; c <= width; c++) begin : g_col
        div_array_cell u_cell (
          .rem_in     (shifted[r][c]),
          .div_bit    (div_row[r][c]),
          .borrow_in  (borrow_row[r][c]),
          .keep       (keep[r]),
          .borrow_out (borrow_row[r][c+1]),
          .rem_out    (rem_row[r][c]),
          .div_pass   (div_row[r+1][c])
        );
      end

      // the result is below the divisor, so the top bit is always zero.
      assign part_rem[r+1] = rem_row[r][width-1:0];
    end
  endgenerate

  assign mag_rem = part_rem[width];

  // the divisor reaching the bottom row bounds the remainder.
  a_rem_below_divisor: assert property (
    @(posedge op.clk)
    (op.valid && op.mag_divisor != '0) |-> (mag_rem < div_row[width][width-1:0])
  );

endmodule

// ==== hw/div_array_cell.sv ====
module div_array_cell (
  input  logic rem_in,
  input  logic div_bit,
  input  logic borrow_in,
  input  logic keep,

  output logic borrow_out,
  output logic rem_out,
  output logic div_pass
);

  logic diff;

  // full subtractor rem_in - div_bit - borrow_in.
  assign diff       = rem_in ^ div_bit ^ borrow_in;
  assign borrow_out = (~rem_in & div_bit) | (~(rem_in ^ div_bit) & borrow_in);

  // restore when the row trial went negative.
  assign rem_out  = keep ? rem_in : diff;
  assign div_pass = div_bit; // divisor bit goes on to the next row.

endmodule

// ==== hw/div_operand_if.sv ====
interface div_operand_if #(
  parameter int width = div_cfg_pkg::default_width
) (
  input logic clk
);

  logic             valid;
  logic             mode_signed;
  logic [width-1:0] dividend;     // raw, as requested.
  logic [width-1:0] divisor;
  logic [width-1:0] mag_dividend;
  logic [width-1:0] mag_divisor;
  logic             neg_quot;
  logic             neg_rem;      // follows the dividend sign.

  modport src (
    output valid, mode_signed, dividend, divisor,
    output mag_dividend, mag_divisor, neg_quot, neg_rem
  );

  modport dst (
    input clk,
    input valid, mode_signed, dividend, divisor,
    input mag_dividend, mag_divisor, neg_quot, neg_rem
  );

endinterface

// ==== hw/div_op_pkg.sv ====
package div_op_pkg;

  typedef enum logic [1:0] {
    none            = 2'd0,
    div_by_zero     = 2'd1,
    signed_overflow = 2'd2
  } except_kind_t;

  // where each result word comes from.
  typedef enum logic [1:0] {
    res_computed = 2'd0, // signed array result.
    res_all_ones = 2'd1,
    res_dividend = 2'd2, // raw registered dividend.
    res_zero     = 2'd3
  } res_src_t;

  // divide by zero.
  localparam res_src_t dbz_quot_src = res_all_ones;
  localparam res_src_t dbz_rem_src  = res_dividend;

  // most negative value divided by minus one.
  localparam res_src_t ovf_quot_src = res_dividend;
  localparam res_src_t ovf_rem_src  = res_zero;

endpackage

// ==== hw/div_cfg_pkg.sv ====
package div_cfg_pkg;

  // operand width used when the top level is not overridden.
  parameter int default_width = 8;

  // one register in the operand stage and one in the merge stage.
  parameter int pipe_latency = 2;

endpackage
